// ==== src/i2c_seq_macros.svh ====
`ifndef I2C_SEQ_MACROS_SVH
`define I2C_SEQ_MACROS_SVH

// register map of the i2c master core
`define I2C_REG_STATUS      3'd0
`define I2C_REG_ADDR        3'd2
`define I2C_REG_CMD         3'd3
`define I2C_REG_DATA        3'd4
`define I2C_REG_PRESC_LO    3'd6
`define I2C_REG_PRESC_HI    3'd7

// command register values
`define I2C_CMD_WR_START    8'h05 // write + start
`define I2C_CMD_WRITE       8'h04 // write only, repeat byte
`define I2C_CMD_STOP        8'h10

// status register bits
`define I2C_STAT_BUSY_BIT   0
`define I2C_STAT_NACK_BIT   3 // missed ack

// control word layout
`define CTRL_WRITE_BIT      3
`define CTRL_PRESCALE_BIT   5
`define CTRL_ADDR_LSB       6  // 7 bit slave address
`define CTRL_LEN_LSB        13 // 4 bit byte count

`define I2C_PRESCALE_VAL    16'd125 // fixed divider

// widths
`define MEM_W               32
`define WB_ADR_W            3
`define WB_DAT_W            8
`define I2C_ADDR_W          7
`define LEN_W               4

`endif

// ==== src/i2c_seq_pkg.sv ====
`default_nettype none

`include "i2c_seq_macros.svh"

package i2c_seq_pkg;

	// what the decoder asks the sequencer to do
	typedef enum logic [1:0] {
		OP_NONE     = 2'd0,
		OP_WRITE    = 2'd1,
		OP_PRESCALE = 2'd2
	} seq_op_e;

	// one decoded command, 13 bits
	typedef struct packed {
		seq_op_e                  op;
		logic [`I2C_ADDR_W-1:0]   addr; // 7 bit slave address
		logic [`LEN_W-1:0]        len;  // bytes to send
	} i2c_cmd_t;

	// one register access on the master bus, 12 bits
	typedef struct packed {
		logic [`WB_ADR_W-1:0]     adr;
		logic [`WB_DAT_W-1:0]     dat; // don't care on reads
		logic                     we;
	} wb_req_t;

endpackage

`default_nettype wire

// ==== src/i2c_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_seq_macros.svh"

module i2c_cmd_decode (
	input  wire                     clk,
	input  wire                     nrst,
	input  wire [`MEM_W-1:0]        memory_control_i,
	input  wire [`MEM_W-1:0]        memory_data_i,
	input  wire                     idle_i,      // sequencer can take a command
	input  wire                     byte_take_i, // low byte consumed
	output i2c_seq_pkg::i2c_cmd_t   cmd_o,
	output logic                    cmd_valid_o,
	output wire [`WB_DAT_W-1:0]     tx_byte_o
);
	import i2c_seq_pkg::*;

	seq_op_e             op_sel;
	logic                load;
	logic [`MEM_W-1:0]   buf_q; // outgoing bytes, low byte next

	// write wins over prescale
	always_comb begin
		op_sel = OP_NONE;
		if (memory_control_i[`CTRL_WRITE_BIT])
			op_sel = OP_WRITE;
		else if (memory_control_i[`CTRL_PRESCALE_BIT])
			op_sel = OP_PRESCALE;
	end

	// sequencer still shows idle during the valid cycle, don't sample twice
	assign load = idle_i && !cmd_valid_o && (op_sel != OP_NONE);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			cmd_valid_o <= 1'b0;
		end else begin
			cmd_valid_o <= load; // one cycle pulse
		end
	end

	// command and data words held until the next load
	always_ff @(posedge clk) begin
		if (load) begin
			cmd_o.op   <= op_sel;
			cmd_o.addr <= memory_control_i[`CTRL_ADDR_LSB +: `I2C_ADDR_W];
			cmd_o.len  <= memory_control_i[`CTRL_LEN_LSB +: `LEN_W];
			buf_q      <= memory_data_i;
		end else if (byte_take_i) begin
			// shift down one byte, zero in at the top
			buf_q <= {{`WB_DAT_W{1'b0}}, buf_q[`MEM_W-1:`WB_DAT_W]};
		end
	end

	assign tx_byte_o = buf_q[`WB_DAT_W-1:0];

endmodule

`default_nettype wire

// ==== src/i2c_write_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_seq_macros.svh"

module i2c_write_sequencer (
	input  wire                     clk,
	input  wire                     nrst,
	input  i2c_seq_pkg::i2c_cmd_t   cmd_i,
	input  wire                     cmd_valid_i,
	input  wire [`WB_DAT_W-1:0]     tx_byte_i,
	input  wire                     acc_done_i,
	input  wire [`WB_DAT_W-1:0]     acc_rdata_i, // status on reads
	output wire                     idle_o,
	output wire                     byte_take_o,
	output wire                     acc_req_o,
	output i2c_seq_pkg::wb_req_t    acc_o,
	output wire                     done_o,
	output wire                     busy_o
);
	import i2c_seq_pkg::*;

	localparam logic [15:0]          PRESC   = `I2C_PRESCALE_VAL;
	localparam logic [`LEN_W-1:0]    CNT_ONE = 'd1;

	typedef enum logic [3:0] {
		S_IDLE,
		S_PRESC_LO,
		S_PRESC_HI,
		S_ADDR,     // slave address register
		S_FILL,     // tx fifo load
		S_START,    // write(+start) command
		S_WAIT_HI,  // poll until busy rises
		S_WAIT_LO,  // poll until busy falls
		S_STOP,
		S_DONE,
		S_ABORT     // stop after missed ack, no done
	} state_e;

	state_e              state_q;
	logic                pend_q;   // access issued, result not back yet
	logic [`LEN_W-1:0]   q_cnt;    // bytes queued in fifo
	logic [`LEN_W-1:0]   sent_cnt; // bytes started on the wire
	logic                need_acc;
	logic                stat_busy;
	logic                stat_nack;

	assign stat_busy = acc_rdata_i[`I2C_STAT_BUSY_BIT];
	assign stat_nack = acc_rdata_i[`I2C_STAT_NACK_BIT];

	// every state but idle and done talks to the core
	assign need_acc    = (state_q != S_IDLE) && (state_q != S_DONE);
	assign acc_req_o   = need_acc && !pend_q;
	assign byte_take_o = acc_req_o && (state_q == S_FILL); // byte leaves with the request

	assign idle_o = (state_q == S_IDLE);
	assign done_o = (state_q == S_DONE);
	assign busy_o = (state_q == S_ADDR) || (state_q == S_FILL) || (state_q == S_START) ||
	                (state_q == S_WAIT_HI) || (state_q == S_WAIT_LO) ||
	                (state_q == S_STOP) || (state_q == S_ABORT);

	// access for the current state
	always_comb begin
		acc_o = '{adr: `I2C_REG_STATUS, dat: '0, we: 1'b0}; // status poll
		case (state_q)
			S_PRESC_LO: acc_o = '{adr: `I2C_REG_PRESC_LO, dat: PRESC[7:0], we: 1'b1};
			S_PRESC_HI: acc_o = '{adr: `I2C_REG_PRESC_HI, dat: PRESC[15:8], we: 1'b1};
			S_ADDR:     acc_o = '{adr: `I2C_REG_ADDR, dat: {1'b0, cmd_i.addr}, we: 1'b1};
			S_FILL:     acc_o = '{adr: `I2C_REG_DATA, dat: tx_byte_i, we: 1'b1};
			S_START: begin
				// start only ahead of the first byte
				if (sent_cnt == '0)
					acc_o = '{adr: `I2C_REG_CMD, dat: `I2C_CMD_WR_START, we: 1'b1};
				else
					acc_o = '{adr: `I2C_REG_CMD, dat: `I2C_CMD_WRITE, we: 1'b1};
			end
			S_STOP, S_ABORT:
				acc_o = '{adr: `I2C_REG_CMD, dat: `I2C_CMD_STOP, we: 1'b1};
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state_q  <= S_IDLE;
			pend_q   <= 1'b0;
			q_cnt    <= '0;
			sent_cnt <= '0;
		end else begin
			if (acc_req_o)
				pend_q <= 1'b1;
			else if (acc_done_i)
				pend_q <= 1'b0;

			case (state_q)
				S_IDLE: begin
					if (cmd_valid_i) begin
						q_cnt    <= '0;
						sent_cnt <= '0;
						if (cmd_i.op == OP_WRITE)
							state_q <= S_ADDR;
						else if (cmd_i.op == OP_PRESCALE)
							state_q <= S_PRESC_LO;
					end
				end
				S_PRESC_LO: if (acc_done_i) state_q <= S_PRESC_HI;
				S_PRESC_HI: if (acc_done_i) state_q <= S_DONE;
				S_ADDR:     if (acc_done_i) state_q <= S_FILL;
				S_FILL: begin
					if (acc_done_i) begin
						q_cnt <= q_cnt + CNT_ONE;
						if (q_cnt + CNT_ONE == cmd_i.len) // whole payload queued
							state_q <= S_START;
					end
				end
				S_START: if (acc_done_i) state_q <= S_WAIT_HI;
				S_WAIT_HI: begin
					if (acc_done_i) begin
						if (stat_busy) begin
							sent_cnt <= sent_cnt + CNT_ONE; // byte on its way
							state_q  <= S_WAIT_LO;
						end else if (stat_nack) begin
							state_q <= S_ABORT;
						end
					end
				end
				S_WAIT_LO: begin
					// nack only valid once busy is low
					if (acc_done_i && !stat_busy) begin
						if (stat_nack)
							state_q <= S_ABORT;
						else if (sent_cnt == cmd_i.len)
							state_q <= S_STOP;
						else
							state_q <= S_START; // next byte
					end
				end
				S_STOP:  if (acc_done_i) state_q <= S_DONE;
				S_ABORT: if (acc_done_i) state_q <= S_IDLE;
				S_DONE:  state_q <= S_IDLE; // single cycle done
				default: state_q <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/wb_reg_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_seq_macros.svh"

module wb_reg_master (
	input  wire                     clk,
	input  wire                     nrst,
	input  wire                     acc_req_i,
	input  i2c_seq_pkg::wb_req_t    acc_i,
	input  wire [`WB_DAT_W-1:0]     wbm_dat_i,
	input  wire                     wbm_ack_i,
	output logic                    acc_done_o,
	output logic [`WB_DAT_W-1:0]    acc_rdata_o,
	output logic [`WB_ADR_W-1:0]    wbm_adr_o,
	output logic [`WB_DAT_W-1:0]    wbm_dat_o,
	output logic                    wbm_we_o,
	output logic                    wbm_stb_o,
	output logic                    wbm_cyc_o
);
	import i2c_seq_pkg::*;

	wb_req_t   req_q; // access currently on the bus
	logic      take;
	logic      fin;

	assign take = acc_req_i && !wbm_stb_o; // one access at a time
	assign fin  = wbm_stb_o && wbm_ack_i;  // core accepted the access

	// bus handshake, stb held until ack
	always_ff @(posedge clk) begin
		if (!nrst) begin
			wbm_stb_o  <= 1'b0;
			wbm_cyc_o  <= 1'b0;
			wbm_we_o   <= 1'b0;
			acc_done_o <= 1'b0;
		end else begin
			acc_done_o <= fin;
			if (fin) begin
				wbm_stb_o <= 1'b0;
				wbm_cyc_o <= 1'b0;
				wbm_we_o  <= 1'b0;
			end else if (take) begin
				wbm_stb_o <= 1'b1;
				wbm_cyc_o <= 1'b1;
				wbm_we_o  <= acc_i.we;
			end
		end
	end

	// address, write data and read data
	always_ff @(posedge clk) begin
		if (take)
			req_q <= acc_i;
		if (fin)
			acc_rdata_o <= wbm_dat_i; // status value for reads
	end

	assign wbm_adr_o = req_q.adr;
	assign wbm_dat_o = req_q.dat;

endmodule

`default_nettype wire

// ==== src/i2c_seq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_seq_macros.svh"

module i2c_seq_top (
	input  wire                     clk,
	input  wire                     nrst,
	input  wire [`MEM_W-1:0]        memory_control_i,
	input  wire [`MEM_W-1:0]        memory_data_i,
	output wire                     done_o,
	output wire                     busy_o,
	output wire [`WB_ADR_W-1:0]     wbm_adr_o,
	output wire [`WB_DAT_W-1:0]     wbm_dat_o,
	output wire                     wbm_we_o,
	output wire                     wbm_stb_o,
	output wire                     wbm_cyc_o,
	input  wire [`WB_DAT_W-1:0]     wbm_dat_i,
	input  wire                     wbm_ack_i
);
	import i2c_seq_pkg::*;

	i2c_cmd_t               cmd;
	wire                    cmd_valid;
	wire                    idle;
	wire                    byte_take;
	wire [`WB_DAT_W-1:0]    tx_byte;
	wb_req_t                acc;
	wire                    acc_req;
	wire                    acc_done;
	wire [`WB_DAT_W-1:0]    acc_rdata;

	// control/data words to command
	i2c_cmd_decode i_decode (
		.clk              (clk),
		.nrst             (nrst),
		.memory_control_i (memory_control_i),
		.memory_data_i    (memory_data_i),
		.idle_i           (idle),
		.byte_take_i      (byte_take),
		.cmd_o            (cmd),
		.cmd_valid_o      (cmd_valid),
		.tx_byte_o        (tx_byte)
	);

	i2c_write_sequencer i_seq (
		.clk         (clk),
		.nrst        (nrst),
		.cmd_i       (cmd),
		.cmd_valid_i (cmd_valid),
		.tx_byte_i   (tx_byte),
		.acc_done_i  (acc_done),
		.acc_rdata_i (acc_rdata),
		.idle_o      (idle),
		.byte_take_o (byte_take),
		.acc_req_o   (acc_req),
		.acc_o       (acc),
		.done_o      (done_o),
		.busy_o      (busy_o)
	);

	// register accesses onto the core bus
	wb_reg_master i_wbm (
		.clk         (clk),
		.nrst        (nrst),
		.acc_req_i   (acc_req),
		.acc_i       (acc),
		.wbm_dat_i   (wbm_dat_i),
		.wbm_ack_i   (wbm_ack_i),
		.acc_done_o  (acc_done),
		.acc_rdata_o (acc_rdata),
		.wbm_adr_o   (wbm_adr_o),
		.wbm_dat_o   (wbm_dat_o),
		.wbm_we_o    (wbm_we_o),
		.wbm_stb_o   (wbm_stb_o),
		.wbm_cyc_o   (wbm_cyc_o)
	);

endmodule

`default_nettype wire

// ==== verif/i2c_core_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_seq_macros.svh"

module i2c_core_model (
	input  wire                     clk,
	input  wire [`WB_ADR_W-1:0]     wb_adr_i,
	input  wire [`WB_DAT_W-1:0]     wb_dat_i,
	input  wire                     wb_we_i,
	input  wire                     wb_stb_i,
	input  wire                     wb_cyc_i,
	output logic [`WB_DAT_W-1:0]    wb_dat_o,
	output logic                    wb_ack_o
);
	integer                   seed;
	integer                   wait_cnt;  // cycles left before ack
	integer                   busy_left; // status reads still showing busy
	logic [`I2C_ADDR_W-1:0]   slave_q;   // latched slave address
	logic                     nack_q;

	initial begin
		seed      = 32'h73bb;
		wait_cnt  = 0;
		busy_left = 0;
		slave_q   = '0;
		nack_q    = 1'b0;
		wb_dat_o  = '0;
		wb_ack_o  = 1'b0;
	end

	// register side effects of one acknowledged access
	task automatic serve_access;
		wb_dat_o = '0;
		if (wb_we_i && wb_adr_i == `I2C_REG_ADDR) begin
			slave_q = wb_dat_i[`I2C_ADDR_W-1:0];
			nack_q  = 1'b0; // new slave, flag cleared
		end else if (wb_we_i && wb_adr_i == `I2C_REG_CMD &&
		             (wb_dat_i == `I2C_CMD_WR_START || wb_dat_i == `I2C_CMD_WRITE)) begin
			busy_left = 1 + (($random(seed) & 32'hff) % 3); // byte on the wire
		end else if (!wb_we_i && wb_adr_i == `I2C_REG_STATUS) begin
			wb_dat_o[`I2C_STAT_BUSY_BIT] = (busy_left > 0);
			wb_dat_o[`I2C_STAT_NACK_BIT] = nack_q;
			if (busy_left > 0) begin
				busy_left = busy_left - 1;
				// slaves with the top address bit set never ack
				if (busy_left == 0 && slave_q[`I2C_ADDR_W-1])
					nack_q = 1'b1;
			end
		end
	endtask

	// bus looked at just after the edge, answer driven in the same step
	always @(posedge clk) begin
		#1;
		if (wb_ack_o) begin
			wb_ack_o = 1'b0; // ack lasts one cycle
		end else if (wb_stb_i && wb_cyc_i) begin
			if (wait_cnt > 0) begin
				wait_cnt = wait_cnt - 1;
			end else begin
				serve_access;
				wb_ack_o = 1'b1;
				wait_cnt = $random(seed) & 32'd3; // delay of the next access
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_i2c_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i2c_seq_macros.svh"

module tb_i2c_seq;
	import i2c_seq_pkg::*;

	localparam integer TIMEOUT = 2000; // cycles per command

	logic                    clk = 1'b0;
	logic                    nrst = 1'b0;
	logic [`MEM_W-1:0]       memory_control_i = '0;
	logic [`MEM_W-1:0]       memory_data_i = '0;
	wire                     done_o;
	wire                     busy_o;
	wire [`WB_ADR_W-1:0]     wbm_adr_o;
	wire [`WB_DAT_W-1:0]     wbm_dat_o;
	wire                     wbm_we_o;
	wire                     wbm_stb_o;
	wire                     wbm_cyc_o;
	wire [`WB_DAT_W-1:0]     wbm_dat_i;
	wire                     wbm_ack_i;

	integer        seed;
	integer        err_cnt = 0;
	integer        mon_err_cnt = 0; // errors seen by the bus monitor
	integer        test_cnt = 0;
	integer        fail_cnt = 0;
	integer        done_cnt = 0;    // running counts kept by the monitor
	integer        busy_rise = 0;
	integer        busy_cyc = 0;
	logic          busy_last = 1'b0;
	logic          stb_held = 1'b0; // strobe up and no ack at last sample
	logic [10:0]   exp_q[$];        // {register, data} per bus write
	logic [10:0]   got_q[$];

	always #5 clk = ~clk;

	i2c_seq_top i_dut (
		.clk(clk), .nrst(nrst),
		.memory_control_i(memory_control_i), .memory_data_i(memory_data_i),
		.done_o(done_o), .busy_o(busy_o),
		.wbm_adr_o(wbm_adr_o), .wbm_dat_o(wbm_dat_o), .wbm_we_o(wbm_we_o),
		.wbm_stb_o(wbm_stb_o), .wbm_cyc_o(wbm_cyc_o),
		.wbm_dat_i(wbm_dat_i), .wbm_ack_i(wbm_ack_i)
	);

	i2c_core_model i_core (
		.clk(clk), .wb_adr_i(wbm_adr_o), .wb_dat_i(wbm_dat_o), .wb_we_i(wbm_we_o),
		.wb_stb_i(wbm_stb_o), .wb_cyc_i(wbm_cyc_o), .wb_dat_o(wbm_dat_i), .wb_ack_o(wbm_ack_i)
	);

	// mid cycle monitor where everything is stable
	always @(negedge clk) begin
		if (nrst) begin
			if (wbm_stb_o && wbm_ack_i && wbm_we_o)
				got_q.push_back({wbm_adr_o, wbm_dat_o});
			if (stb_held && !wbm_stb_o) begin
				$display("ERROR %0t wbm_stb_o: got 0 expected 1, dropped before ack", $time);
				mon_err_cnt++;
			end
			if (wbm_cyc_o !== wbm_stb_o) begin
				$display("ERROR %0t wbm_cyc_o: got %b expected %b", $time, wbm_cyc_o, wbm_stb_o);
				mon_err_cnt++;
			end
			stb_held = wbm_stb_o && !wbm_ack_i;
			if (done_o) done_cnt++;
			if (busy_o && !busy_last) busy_rise++;
			if (busy_o) busy_cyc++;
			busy_last = busy_o;
		end
	end

	// bus writes that one command should cause
	task automatic build_expected(input seq_op_e op, input logic [6:0] addr,
		input logic [3:0] len, input logic [31:0] data);
		integer      i;
		logic [31:0] rest; // bytes not yet queued
		exp_q.delete();
		rest = data;
		if (op == OP_PRESCALE) begin
			exp_q.push_back({`I2C_REG_PRESC_LO, 8'd125});
			exp_q.push_back({`I2C_REG_PRESC_HI, 8'd0});
		end else begin
			exp_q.push_back({`I2C_REG_ADDR, 1'b0, addr});
			for (i = 0; i < int'(len); i++) begin
				exp_q.push_back({`I2C_REG_DATA, rest[7:0]}); // low byte first
				rest = rest >> 8;
			end
			exp_q.push_back({`I2C_REG_CMD, `I2C_CMD_WR_START});
			if (!addr[6]) begin
				for (i = 1; i < int'(len); i++)
					exp_q.push_back({`I2C_REG_CMD, `I2C_CMD_WRITE});
			end
			exp_q.push_back({`I2C_REG_CMD, `I2C_CMD_STOP}); // stop on nack too
		end
	endtask

	task automatic close_test(input string name, input integer err_start);
		test_cnt++;
		if (err_cnt + mon_err_cnt == err_start) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			$display("test %0d %s: FAILED", test_cnt, name);
			fail_cnt++;
		end
	endtask

	// raise the command bit, wait for the end, compare
	task automatic run_cmd(input seq_op_e op, input logic [6:0] addr, input logic [3:0] len,
		input logic [31:0] data, input string name);
		integer start;
		integer err_start;
		integer done_start;
		integer rise_start;
		integer cyc_start;
		integer n;
		logic   nack;
		logic   fin;
		logic   busy_seen;
		build_expected(op, addr, len, data);
		nack       = (op == OP_WRITE) && addr[6];
		start      = got_q.size();
		err_start  = err_cnt + mon_err_cnt;
		done_start = done_cnt;
		rise_start = busy_rise;
		cyc_start  = busy_cyc;
		@(posedge clk);
		#1;
		memory_data_i    = data;
		memory_control_i = '0;
		if (op == OP_WRITE) begin
			memory_control_i[`CTRL_WRITE_BIT]                = 1'b1;
			memory_control_i[`CTRL_ADDR_LSB +: `I2C_ADDR_W] = addr;
			memory_control_i[`CTRL_LEN_LSB +: `LEN_W]       = len;
		end else begin
			memory_control_i[`CTRL_PRESCALE_BIT] = 1'b1;
		end
		n         = 0;
		fin       = 1'b0;
		busy_seen = 1'b0;
		while (!fin && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
			busy_seen = busy_seen | busy_o;
			fin       = done_o || (busy_seen && !busy_o); // done or busy gone after nack
		end
		memory_control_i = '0; // cleared before the decoder samples it again
		if (!fin) begin
			$display("%s: neither done nor end of busy within %0d cycles", name, TIMEOUT);
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			repeat (3) @(posedge clk);
			#1;
			if (got_q.size() - start != exp_q.size()) begin
				$display("ERROR %0t bus write count: got %0d expected %0d", $time,
					got_q.size() - start, exp_q.size());
				err_cnt++;
			end else begin
				for (n = 0; n < exp_q.size(); n++) begin
					if (got_q[start + n][10:8] != exp_q[n][10:8]) begin
						$display("ERROR %0t wbm_adr_o write %0d: got %0d expected %0d", $time,
							n, got_q[start + n][10:8], exp_q[n][10:8]);
						err_cnt++;
					end
					if (got_q[start + n][7:0] != exp_q[n][7:0]) begin
						$display("ERROR %0t wbm_dat_o write %0d: got %h expected %h", $time,
							n, got_q[start + n][7:0], exp_q[n][7:0]);
						err_cnt++;
					end
				end
			end
			if (done_cnt - done_start != (nack ? 0 : 1)) begin
				$display("ERROR %0t done_o cycles: got %0d expected %0d", $time,
					done_cnt - done_start, nack ? 0 : 1);
				err_cnt++;
			end
			if (op == OP_PRESCALE && busy_cyc != cyc_start) begin
				$display("ERROR %0t busy_o cycles: got %0d expected 0", $time,
					busy_cyc - cyc_start);
				err_cnt++;
			end
			if (op == OP_WRITE && busy_rise - rise_start != 1) begin
				$display("ERROR %0t busy_o rises: got %0d expected 1", $time,
					busy_rise - rise_start);
				err_cnt++;
			end
			close_test($sformatf("%s addr=%h len=%0d", name, addr, len), err_start);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		integer      i;
		seed = 32'h73bb;
		repeat (8) @(posedge clk);
		#1;
		nrst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		if (wbm_stb_o || wbm_cyc_o || done_o || busy_o) begin
			$display("ERROR %0t wbm_stb_o/wbm_cyc_o/done_o/busy_o: got %b%b%b%b expected 0000",
				$time, wbm_stb_o, wbm_cyc_o, done_o, busy_o);
			err_cnt++;
		end
		close_test("after reset", 0);

		run_cmd(OP_PRESCALE, 7'h00, 4'd0, 32'h0, "prescale");
		run_cmd(OP_WRITE, 7'h2a, 4'd4, 32'h8c3f_51a7, "write ack");
		run_cmd(OP_WRITE, 7'h51, 4'd2, 32'h0000_e419, "write nack"); // top bit set
		run_cmd(OP_WRITE, 7'h13, 4'd1, 32'h0000_006d, "write after nack");

		// random mix with about one prescale in four
		for (i = 0; i < 40; i++) begin
			r = $random(seed);
			d = $random(seed);
			if (r[12:11] == 2'b00)
				run_cmd(OP_PRESCALE, r[6:0], 4'd0, d, "random prescale");
			else
				run_cmd(OP_WRITE, r[6:0], {2'b00, r[9:8]} + 4'd1, d, "random write");
		end

		$display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt,
			err_cnt + mon_err_cnt);
		if (fail_cnt == 0 && err_cnt + mon_err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/i2c_seq_pkg.sv
src/i2c_cmd_decode.sv
src/i2c_write_sequencer.sv
src/wb_reg_master.sv
src/i2c_seq_top.sv
verif/i2c_core_model.sv
verif/tb_i2c_seq.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_i2c_seq
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
